//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    typedef logic [63:0] xlen_t;     // Data and address word
    typedef logic [31:0] inst_t;     // Instruction word
    typedef logic [4:0]  reg_addr_t; // Register index
    typedef logic [11:0] csr_addr_t; // CSR address

    // Execute stage FSM, LOAD_KEY needs a second pass
    typedef enum logic {
        EXE_RUN,
        EXE_LOAD_WAIT
    } exe_state_t;

    // Address map
    localparam xlen_t RAM_BASE = 64'h0000_0000_1000_0000; // Reset PC, ROM window
    localparam xlen_t KEY_BASE = 64'h0000_0000_2000_0000; // Key input register
    localparam xlen_t ART_BASE = 64'h0000_0000_2000_0008; // ART output register

    // Major opcodes
    localparam logic [6:0] OP_LUI       = 7'b0110111;
    localparam logic [6:0] OP_ADDI      = 7'b0010011; // OP-IMM group
    localparam logic [6:0] OP_JAL       = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM    = 7'b1110011;
    localparam logic [6:0] OP_LOAD_KEY  = 7'b0001011; // custom-0
    localparam logic [6:0] OP_STORE_ART = 7'b0101011; // custom-1

    localparam logic [2:0] FUNCT3_ADDI  = 3'b000;
    localparam logic [2:0] FUNCT3_CSRRW = 3'b001;

    localparam inst_t INST_MRET = 32'h3020_0073;
    localparam inst_t INST_NOP  = 32'h0000_0013; // ADDI x0,x0,0

    // Machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;
    localparam csr_addr_t CSR_MIP     = 12'h344;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MEIE_BIT     = 11; // Same position as MEIP in mip

    localparam xlen_t MCAUSE_MEI = 64'h8000_0000_0000_000B; // Interrupt, code 11

endpackage

`default_nettype wire

//--- riscv64.sv
`default_nettype none

module riscv64 (
    input  wire                   clk,
    input  wire                   reset,
    input  wire riscv_pkg::inst_t instruction,
    input  wire riscv_pkg::xlen_t bus_read_data,
    input  wire                   irq_take,
    input  wire riscv_pkg::xlen_t mtvec,
    input  wire riscv_pkg::xlen_t mepc,
    input  wire riscv_pkg::xlen_t csr_rdata,
    output riscv_pkg::xlen_t      pc,
    output logic                  heartbeat,
    output riscv_pkg::xlen_t      bus_address,
    output riscv_pkg::xlen_t      bus_write_data,
    output logic                  bus_write_enable,
    output logic                  bus_read_enable,
    output riscv_pkg::csr_addr_t  csr_addr,
    output riscv_pkg::xlen_t      csr_wdata,
    output logic                  csr_we,
    output logic                  trap_take,
    output riscv_pkg::xlen_t      trap_pc,
    output logic                  mret
);
    import riscv_pkg::*;

    inst_t      ir;       // Word in EXE
    xlen_t      ir_pc;    // Its address
    logic       bubble;   // ir holds a wrongly fetched word
    exe_state_t exe_state;

    xlen_t      regs [32]; // x0 is never written and reads as zero

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    xlen_t      imm_u;
    xlen_t      imm_i;
    xlen_t      imm_j;
    xlen_t      rs1_val;
    xlen_t      rs2_val;

    logic       exe_run;  // Normal execute slot
    logic       load_done; // Second pass of LOAD_KEY
    logic       is_lui;
    logic       is_addi;
    logic       is_jal;
    logic       is_csrrw;
    logic       is_mret;
    logic       is_load_key;
    logic       is_store_art;

    logic       rf_we;
    xlen_t      rf_wdata;

    // Field split and immediates
    always_comb begin
        opcode = ir[6:0];
        funct3 = ir[14:12];
        rd     = ir[11:7];
        rs1    = ir[19:15];
        rs2    = ir[24:20];
        imm_u  = {{32{ir[31]}}, ir[31:12], 12'b0};
        imm_i  = {{52{ir[31]}}, ir[31:20]};
        imm_j  = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
        rs1_val = (rs1 == '0) ? '0 : regs[rs1];
        rs2_val = (rs2 == '0) ? '0 : regs[rs2];
    end

    always_comb begin
        is_lui       = (opcode == OP_LUI);
        is_addi      = (opcode == OP_ADDI) && (funct3 == FUNCT3_ADDI);
        is_jal       = (opcode == OP_JAL);
        is_csrrw     = (opcode == OP_SYSTEM) && (funct3 == FUNCT3_CSRRW);
        is_mret      = (ir == INST_MRET);
        is_load_key  = (opcode == OP_LOAD_KEY);
        is_store_art = (opcode == OP_STORE_ART);
    end

    // Trap replaces the instruction in EXE
    always_comb begin
        trap_take = !bubble && (exe_state == EXE_RUN) && irq_take;
        exe_run   = !bubble && (exe_state == EXE_RUN) && !irq_take;
        load_done = !bubble && (exe_state == EXE_LOAD_WAIT);
    end

    assign trap_pc   = ir_pc;      // Resume at the replaced instruction
    assign csr_addr  = ir[31:20];
    assign csr_wdata = rs1_val;
    assign csr_we    = exe_run && is_csrrw;
    assign mret      = exe_run && is_mret;

    // Write-back select
    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = '0;
        if (load_done) begin
            rf_we    = 1'b1;
            rf_wdata = bus_read_data; // Registered by the bus last cycle
        end else if (exe_run) begin
            if (is_lui) begin
                rf_we    = 1'b1;
                rf_wdata = imm_u;
            end else if (is_addi) begin
                rf_we    = 1'b1;
                rf_wdata = rs1_val + imm_i;
            end else if (is_jal) begin
                rf_we    = 1'b1;
                rf_wdata = ir_pc + 64'd4; // Link address
            end else if (is_csrrw) begin
                rf_we    = 1'b1;
                rf_wdata = csr_rdata; // Old CSR value
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we && rd != '0) begin
            regs[rd] <= rf_wdata;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heartbeat        <= 1'b0;
            ir               <= INST_NOP;
            ir_pc            <= RAM_BASE;
            pc               <= RAM_BASE;
            bubble           <= 1'b0;
            exe_state        <= EXE_RUN;
            bus_address      <= '0;
            bus_write_data   <= '0;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
        end else begin
            heartbeat        <= ~heartbeat;
            ir               <= instruction; // Fetch
            ir_pc            <= pc;
            pc               <= pc + 64'd4;   // Default step unless redirected
            bubble           <= 1'b0;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
            if (trap_take) begin
                pc     <= mtvec;
                bubble <= 1'b1;
            end else if (exe_run) begin
                if (is_jal) begin
                    pc     <= ir_pc + imm_j;
                    bubble <= 1'b1;
                end
                if (is_mret) begin
                    pc     <= mepc;
                    bubble <= 1'b1;
                end
                if (is_load_key) begin
                    bus_address     <= KEY_BASE;
                    bus_read_enable <= 1'b1;
                    pc              <= pc - 64'd4; // Refetch LOAD_KEY for the second pass
                    bubble          <= 1'b1;
                    exe_state       <= EXE_LOAD_WAIT;
                end
                if (is_store_art) begin
                    bus_address      <= ART_BASE;
                    bus_write_data   <= rs2_val;
                    bus_write_enable <= 1'b1;
                end
            end else if (load_done) begin
                exe_state <= EXE_RUN;
            end
        end
    end

    // Bus strobes are exclusive
    assert property (@(posedge clk) disable iff (!reset)
        !(bus_read_enable && bus_write_enable))
        else $error("bus read and write strobes overlap");

    // Second pass of LOAD_KEY finds the refetched LOAD_KEY in EXE
    assert property (@(posedge clk) disable iff (!reset)
        load_done |-> is_load_key)
        else $error("LOAD_KEY second pass without LOAD_KEY in EXE");

endmodule

`default_nettype wire

//--- csr_file.sv
`default_nettype none

module csr_file (
    input  wire                       clk,
    input  wire                       reset,
    input  wire riscv_pkg::csr_addr_t csr_addr,
    input  wire riscv_pkg::xlen_t     csr_wdata,
    input  wire                       csr_we,
    input  wire                       trap_take,
    input  wire riscv_pkg::xlen_t     trap_pc,
    input  wire                       mret,
    input  wire                       irq_req,
    output riscv_pkg::xlen_t          csr_rdata,
    output riscv_pkg::xlen_t          mtvec,
    output riscv_pkg::xlen_t          mepc,
    output logic                      irq_take
);
    import riscv_pkg::*;

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mcause;
    xlen_t mip_value;
    logic  meip;      // Only pending bit and owned by hardware
    logic  irq_req_q; // Edge detect

    always_comb begin
        mip_value               = '0;
        mip_value[MIE_MEIE_BIT] = meip;
    end

    // Pending, enabled and globally unmasked
    assign irq_take = meip && mie[MIE_MEIE_BIT] && mstatus[MSTATUS_MIE_BIT];

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MIE:     csr_rdata = mie;
            CSR_MIP:     csr_rdata = mip_value;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus   <= '0;
            mie       <= '0;
            mtvec     <= '0;
            mepc      <= '0;
            mcause    <= '0;
            meip      <= 1'b0;
            irq_req_q <= 1'b0;
        end else begin
            irq_req_q <= irq_req;
            if (csr_we) begin
                case (csr_addr)
                    CSR_MSTATUS: mstatus <= csr_wdata;
                    CSR_MIE:     mie     <= csr_wdata;
                    CSR_MTVEC:   mtvec   <= csr_wdata;
                    CSR_MEPC:    mepc    <= csr_wdata;
                    CSR_MCAUSE:  mcause  <= csr_wdata;
                    default: ; // mip is read only here
                endcase
            end
            if (trap_take) begin
                mepc                      <= trap_pc;
                mcause                    <= MCAUSE_MEI;
                mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                mstatus[MSTATUS_MIE_BIT]  <= 1'b0; // No nesting
                meip                      <= 1'b0;
            end else if (mret) begin
                mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
                mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
            end
            if (irq_req && !irq_req_q) begin
                meip <= 1'b1; // New edge wins over a same-cycle clear
            end
        end
    end

    // Core only traps on a live request
    assert property (@(posedge clk) disable iff (!reset)
        trap_take |-> irq_take)
        else $error("trap_take while irq_take is low");

endmodule

`default_nettype wire

//--- inst_rom.sv
`default_nettype none

module inst_rom (
    input  wire riscv_pkg::xlen_t pc,
    output riscv_pkg::inst_t      instruction
);
    import riscv_pkg::*;

    always_comb begin
        instruction = INST_NOP; // Outside the window or unused slot
        if (pc[63:7] == RAM_BASE[63:7]) begin
            case (pc[6:2])
                5'h00: instruction = 32'h1000_00B7; // LUI x1,0x10000
                5'h01: instruction = 32'h0400_8093; // ADDI x1,x1,0x40
                5'h02: instruction = 32'h3050_9073; // CSRRW x0,mtvec,x1
                5'h03: instruction = 32'h4000_0193; // ADDI x3,x0,0x400
                5'h04: instruction = 32'h4001_8193; // ADDI x3,x3,0x400
                5'h05: instruction = 32'h3041_9073; // CSRRW x0,mie,x3
                5'h06: instruction = 32'h0080_0113; // ADDI x2,x0,8
                5'h07: instruction = 32'h3001_1073; // CSRRW x0,mstatus,x2
                // Main loop
                5'h08: instruction = 32'h0000_028B; // LOAD_KEY x5
                5'h09: instruction = 32'h0050_002B; // STORE_ART x5
                5'h0A: instruction = 32'h0012_8293; // ADDI x5,x5,1
                5'h0B: instruction = 32'h0050_002B; // STORE_ART x5
                5'h0C: instruction = 32'hFF1F_F06F; // JAL x0,-16
                // Interrupt handler at offset 0x40
                5'h10: instruction = 32'h1234_5337; // LUI x6,0x12345
                5'h11: instruction = 32'h0060_002B; // STORE_ART x6
                5'h12: instruction = INST_MRET;
                default: instruction = INST_NOP;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- periph_bus.sv
`default_nettype none

module periph_bus (
    input  wire                   clk,
    input  wire                   reset,
    input  wire riscv_pkg::xlen_t bus_address,
    input  wire riscv_pkg::xlen_t bus_write_data,
    input  wire                   bus_write_enable,
    input  wire                   bus_read_enable,
    input  wire riscv_pkg::xlen_t key_in,
    output riscv_pkg::xlen_t      bus_read_data,
    output riscv_pkg::xlen_t      art_data,
    output logic                  art_valid
);
    import riscv_pkg::*;

    xlen_t key_meta;  // First sync stage
    xlen_t key_sync;  // Safe to use
    logic  key_hit;
    logic  art_hit;

    assign key_hit = (bus_address == KEY_BASE);
    assign art_hit = bus_write_enable && (bus_address == ART_BASE);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_meta      <= '0;
            key_sync      <= '0;
            bus_read_data <= '0;
            art_valid     <= 1'b0;
        end else begin
            key_meta  <= key_in;
            key_sync  <= key_meta;
            art_valid <= art_hit; // One cycle after the write strobe
            if (bus_read_enable) begin
                bus_read_data <= key_hit ? key_sync : '0; // Unmapped reads give zero
            end
        end
    end

    // ART payload
    always_ff @(posedge clk) begin
        if (art_hit) begin
            art_data <= bus_write_data;
        end
    end

endmodule

`default_nettype wire

//--- soc_top.sv
`default_nettype none

module soc_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire riscv_pkg::xlen_t key_in,
    input  wire                   irq_req,
    output riscv_pkg::xlen_t      art_data,
    output logic                  art_valid,
    output logic                  irq_ack,
    output logic                  heartbeat
);
    import riscv_pkg::*;

    xlen_t     pc;
    inst_t     instruction;
    xlen_t     bus_address;
    xlen_t     bus_write_data;
    xlen_t     bus_read_data;
    logic      bus_write_enable;
    logic      bus_read_enable;
    csr_addr_t csr_addr;
    xlen_t     csr_wdata;
    xlen_t     csr_rdata;
    logic      csr_we;
    logic      trap_take;
    xlen_t     trap_pc;
    logic      mret;
    logic      irq_take;
    xlen_t     mtvec;
    xlen_t     mepc;

    assign irq_ack = trap_take; // Acknowledge on trap entry

    riscv64 u_core (
        .clk, .reset, .instruction, .bus_read_data, .irq_take, .mtvec, .mepc,
        .csr_rdata, .pc, .heartbeat, .bus_address, .bus_write_data,
        .bus_write_enable, .bus_read_enable, .csr_addr, .csr_wdata, .csr_we,
        .trap_take, .trap_pc, .mret
    );

    csr_file u_csr (
        .clk, .reset, .csr_addr, .csr_wdata, .csr_we, .trap_take, .trap_pc,
        .mret, .irq_req, .csr_rdata, .mtvec, .mepc, .irq_take
    );

    inst_rom u_rom (
        .pc,
        .instruction
    );

    periph_bus u_bus (
        .clk, .reset, .bus_address, .bus_write_data, .bus_write_enable,
        .bus_read_enable, .key_in, .bus_read_data, .art_data, .art_valid
    );

endmodule

`default_nettype wire

//--- tb_soc.sv
`default_nettype none

module tb_soc;
    import riscv_pkg::*;

    localparam xlen_t HANDLER_ART = 64'h0000_0000_1234_5000; // LUI x6,0x12345 in the handler
    localparam int    ART_TIMEOUT = 64; // Cycles allowed per ART output
    localparam int    ACK_TIMEOUT = 64; // Cycles allowed per irq_ack

    logic  clk;
    logic  reset;
    xlen_t key_in;
    logic  irq_req;
    xlen_t art_data;
    logic  art_valid;
    logic  irq_ack;
    logic  heartbeat;

    // Output log, filled by the monitor
    xlen_t art_q[$];
    int    art_ack_q[$]; // irq_ack count when each output appeared
    int    ack_count;    // irq_ack pulses since reset
    logic  ack_prev;

    // Reference model of the program output
    xlen_t cur_key;      // Key the main loop should be echoing
    logic  phase;        // High when key+1 is due next
    int    handler_seen; // Handler outputs since reset

    soc_top u_dut (
        .clk, .reset, .key_in, .irq_req, .art_data, .art_valid, .irq_ack, .heartbeat
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Outputs change on posedge, sample them on negedge
    always @(negedge clk) begin
        if (art_valid) begin
            art_q.push_back(art_data);
            art_ack_q.push_back(ack_count);
        end
        if (irq_ack) begin
            assert (!ack_prev) else report_failure("irq_ack stayed high for more than one cycle");
            ack_count++;
        end
        ack_prev = irq_ack;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t expected);
        assert (got === expected) else
            report_failure($sformatf("[ERROR] %s: expected %h, got %h", name, expected, got));
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        assert (got === expected) else
            report_failure($sformatf("[ERROR] %s: expected %h, got %h", name, expected, got));
    endtask

    // Random 64-bit key that cannot be mistaken for the handler value or an old pair
    function automatic xlen_t pick_key(input xlen_t avoid);
        xlen_t k;
        int    tries;
        k = {$urandom(), $urandom()};
        for (tries = 0; tries < 16; tries++) begin
            if (k != HANDLER_ART && k + 64'd1 != HANDLER_ART && k != avoid &&
                k != avoid + 64'd1 && k + 64'd1 != avoid) begin
                break;
            end
            k = {$urandom(), $urandom()};
        end
        return k;
    endfunction

    task automatic clear_model(input xlen_t key);
        art_q.delete();
        art_ack_q.delete();
        ack_count    = 0;
        handler_seen = 0;
        phase        = 1'b0; // Program starts with a fresh pair
        cur_key      = key;
    endtask

    // Reset held for 5 cycles, key applied while in reset
    task automatic apply_reset(input xlen_t key);
        int cyc;
        @(negedge clk);
        reset  = 1'b0;
        key_in = key;
        for (cyc = 0; cyc < 5; cyc++) begin
            @(negedge clk);
            if (cyc == 0) begin
                clear_model(key); // Outputs are forced low by now
            end
            check_bit("art_valid", art_valid, 1'b0);
            check_bit("irq_ack", irq_ack, 1'b0);
            check_bit("heartbeat", heartbeat, 1'b0);
        end
        reset = 1'b1;
    endtask

    task automatic pulse_irq();
        @(negedge clk);
        irq_req = 1'b1;
        @(negedge clk);
        irq_req = 1'b0;
    endtask

    task automatic pop_art(output xlen_t value, output int ack_at);
        int waited;
        waited = 0;
        while (art_q.size() == 0 && waited < ART_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (art_q.size() != 0) else report_failure("Timed out waiting for art_valid");
        value  = art_q.pop_front();
        ack_at = art_ack_q.pop_front();
    endtask

    task automatic wait_for_ack(input int target);
        int waited;
        waited = 0;
        while (ack_count < target && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (ack_count >= target) else report_failure("Timed out waiting for irq_ack");
    endtask

    // Next ART output against the model, handler values may sit anywhere
    task automatic check_output(output logic was_handler, output int ack_at);
        xlen_t v;
        xlen_t expected;
        pop_art(v, ack_at);
        was_handler = (v == HANDLER_ART);
        if (was_handler) begin
            handler_seen++;
            assert (ack_at >= handler_seen) else
                report_failure("Handler output appeared before its irq_ack");
        end else begin
            expected = phase ? cur_key + 64'd1 : cur_key;
            check_value("art_data", v, expected);
            phase = !phase;
        end
    endtask

    task automatic drain_outputs();
        logic h;
        int   a;
        while (art_q.size() != 0) begin
            check_output(h, a);
        end
    endtask

    task automatic test_reset_state(input xlen_t key);
        int   cyc;
        logic expected_hb;
        apply_reset(key);
        expected_hb = 1'b0;
        for (cyc = 0; cyc < 8; cyc++) begin
            check_bit("heartbeat", heartbeat, expected_hb);
            if (cyc < 4) begin // Program has not reached a store yet
                check_bit("art_valid", art_valid, 1'b0);
                check_bit("irq_ack", irq_ack, 1'b0);
            end
            expected_hb = !expected_hb;
            @(negedge clk);
        end
    endtask

    task automatic test_key_echo();
        int   i;
        logic h;
        int   a;
        for (i = 0; i < 6; i++) begin
            check_output(h, a);
            assert (!h) else report_failure("Handler output without any interrupt request");
        end
        check_value("irq_ack count", 64'(ack_count), 64'd0);
    endtask

    task automatic test_key_change();
        xlen_t new_key;
        xlen_t v;
        int    a;
        int    n;
        logic  found;
        logic  h;
        new_key = pick_key(cur_key);
        @(negedge clk);
        key_in = new_key;
        found  = 1'b0;
        for (n = 0; n < 8 && !found; n++) begin
            pop_art(v, a);
            if (v == new_key) begin
                found = 1'b1;
            end else begin
                check_value("art_data", v, phase ? cur_key + 64'd1 : cur_key); // Old pairs
                phase = !phase;
            end
        end
        assert (found) else report_failure("New key never reached the ART output");
        assert (!phase) else report_failure("New key appeared in the middle of a pair");
        cur_key = new_key;
        phase   = 1'b1; // new_key already seen
        for (n = 0; n < 3; n++) begin
            check_output(h, a);
            assert (!h) else report_failure("Handler output without any interrupt request");
        end
    endtask

    task automatic test_interrupt_service();
        int   base;
        int   handlers;
        int   i;
        logic h;
        int   a;
        drain_outputs();
        base     = ack_count;
        handlers = handler_seen;
        pulse_irq();
        wait_for_ack(base + 1);
        for (i = 0; i < 8; i++) begin
            check_output(h, a); // Pairs must survive the handler
        end
        check_value("handler outputs", 64'(handler_seen), 64'(handlers + 1));
        check_value("irq_ack count", 64'(ack_count), 64'(base + 1));
    endtask

    // Request while MIE is still clear must stay pending
    task automatic test_early_request();
        int   i;
        logic h;
        int   a;
        apply_reset(pick_key(cur_key));
        pulse_irq();
        wait_for_ack(1);
        for (i = 0; i < 7; i++) begin
            check_output(h, a);
        end
        check_value("handler outputs", 64'(handler_seen), 64'd1);
        check_value("irq_ack count", 64'(ack_count), 64'd1);
    endtask

    task automatic test_no_nesting();
        int   base;
        int   handlers;
        int   i;
        logic h;
        int   a;
        drain_outputs();
        base     = ack_count;
        handlers = handler_seen;
        pulse_irq();
        wait_for_ack(base + 1);
        foreach (art_q[j]) begin
            assert (art_q[j] != HANDLER_ART) else
                report_failure("Handler finished before the second request could be sent");
        end
        pulse_irq(); // Lands while the handler runs with MIE clear
        for (i = 0; i < 12 && handler_seen < handlers + 2; i++) begin
            check_output(h, a);
            if (h && handler_seen == handlers + 1) begin
                check_value("irq_ack count", 64'(a), 64'(base + 1)); // No second ack yet
            end
            if (h && handler_seen == handlers + 2) begin
                check_value("irq_ack count", 64'(a), 64'(base + 2));
            end
        end
        check_value("handler outputs", 64'(handler_seen), 64'(handlers + 2));
        for (i = 0; i < 4; i++) begin
            check_output(h, a);
            assert (!h) else report_failure("Extra handler output after two requests");
        end
        check_value("irq_ack count", 64'(ack_count), 64'(base + 2));
    endtask

    initial begin
        xlen_t first_key;
        reset        = 1'b0;
        key_in       = '0;
        irq_req      = 1'b0;
        ack_count    = 0;
        ack_prev     = 1'b0;
        handler_seen = 0;
        phase        = 1'b0;
        cur_key      = '0;
        void'($urandom(32'hbfe62693));
        first_key = pick_key(HANDLER_ART);

        test_reset_state(first_key);
        test_key_echo();
        test_key_change();
        test_interrupt_service();
        test_early_request();
        test_no_nesting();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
riscv_pkg.sv
riscv64.sv
csr_file.sv
inst_rom.sv
periph_bus.sv
soc_top.sv
tb_soc.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_soc -f vlog.f -o tb_soc
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_soc
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
